// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  mips_pkg::word_t     id_pc4,
	input  mips_pkg::word_t     id_instr,
	input  logic                stall,
	input  logic                redirect,
	input  logic                wb_we,
	input  mips_pkg::reg_addr_t wb_dst,
	input  mips_pkg::word_t     wb_data,
	output mips_pkg::word_t     ex_pc4,
	output mips_pkg::word_t     ex_rs_val,
	output mips_pkg::word_t     ex_rt_val,
	output mips_pkg::word_t     ex_imm,
	output logic [25:0]         ex_jtarget_idx,
	output mips_pkg::reg_addr_t ex_rs,
	output mips_pkg::reg_addr_t ex_rt,
	output mips_pkg::reg_addr_t ex_dst,
	output mips_pkg::alu_op_e   ex_alu_op,
	output logic                ex_alu_src_imm,
	output logic                ex_branch,
	output logic                ex_branch_ne,
	output logic                ex_jump,
	output logic                ex_mem_we,
	output logic                ex_mem_load,
	output logic                ex_reg_we
);

	mips_pkg::word_t     rf [32];
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	mips_pkg::reg_addr_t dst;
	mips_pkg::word_t     rs_val;
	mips_pkg::word_t     rt_val;
	mips_pkg::word_t     imm;
	mips_pkg::alu_op_e   alu_op;
	logic                alu_src_imm;
	logic                branch;
	logic                branch_ne;
	logic                jump;
	logic                mem_we;
	logic                mem_load;
	logic                reg_we;
	logic                dst_rd;
	logic                imm_zero;
	logic                imm_lui;
	logic                bubble;

	assign rs = id_instr[25:21];
	assign rt = id_instr[20:16];
	assign rd = id_instr[15:11];

	// ------------------------------------------------------------------------
	// Register file, write-through on same-cycle write
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wb_we && wb_dst != '0) begin
			rf[wb_dst] <= wb_data;
		end
	end

	assign rs_val = (rs == '0) ? '0 : (wb_we && wb_dst == rs) ? wb_data : rf[rs];
	assign rt_val = (rt == '0) ? '0 : (wb_we && wb_dst == rt) ? wb_data : rf[rt];

	// ------------------------------------------------------------------------
	// Main and ALU decoders
	// ------------------------------------------------------------------------
	always_comb begin
		alu_op      = mips_pkg::ALU_ADD;
		alu_src_imm = 1'b0;
		branch      = 1'b0;
		branch_ne   = 1'b0;
		jump        = 1'b0;
		mem_we      = 1'b0;
		mem_load    = 1'b0;
		reg_we      = 1'b0;
		dst_rd      = 1'b0;
		imm_zero    = 1'b0;
		imm_lui     = 1'b0;
		case (mips_pkg::opcode_e'(id_instr[31:26]))
			mips_pkg::OP_RTYPE: begin
				reg_we = 1'b1;
				dst_rd = 1'b1;
				case (mips_pkg::funct_e'(id_instr[5:0]))
					mips_pkg::F_ADD, mips_pkg::F_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::F_SUB, mips_pkg::F_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_OR:                    alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_SLT:                   alu_op = mips_pkg::ALU_SLT;
					default:                           alu_op = mips_pkg::ALU_AND;
				endcase
			end
			mips_pkg::OP_LW: begin
				alu_src_imm = 1'b1;
				mem_load    = 1'b1;
				reg_we      = 1'b1;
			end
			mips_pkg::OP_SW: begin
				alu_src_imm = 1'b1;
				mem_we      = 1'b1;
			end
			mips_pkg::OP_BEQ: branch = 1'b1;
			mips_pkg::OP_BNE: begin
				branch    = 1'b1;
				branch_ne = 1'b1;
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
				alu_src_imm = 1'b1;
				reg_we      = 1'b1;
			end
			mips_pkg::OP_ORI: begin
				alu_op      = mips_pkg::ALU_OR;
				alu_src_imm = 1'b1;
				reg_we      = 1'b1;
				imm_zero    = 1'b1;
			end
			mips_pkg::OP_LUI: begin
				alu_op      = mips_pkg::ALU_OR;	// rs field is r0
				alu_src_imm = 1'b1;
				reg_we      = 1'b1;
				imm_lui     = 1'b1;
			end
			mips_pkg::OP_J: jump = 1'b1;
			default: ;	// Unknown opcode runs as no-op
		endcase
	end

	always_comb begin
		if (imm_lui) begin
			imm = {id_instr[15:0], 16'h0000};
		end else if (imm_zero) begin
			imm = {16'h0000, id_instr[15:0]};
		end else begin
			imm = {{16{id_instr[15]}}, id_instr[15:0]};
		end
	end

	assign dst    = reg_we ? (dst_rd ? rd : rt) : '0;
	assign bubble = stall | redirect;

	// ------------------------------------------------------------------------
	// ID/EX register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_rs          <= '0;
			ex_rt          <= '0;
			ex_dst         <= '0;
			ex_alu_op      <= mips_pkg::ALU_AND;
			ex_alu_src_imm <= 1'b0;
			ex_branch      <= 1'b0;
			ex_branch_ne   <= 1'b0;
			ex_jump        <= 1'b0;
			ex_mem_we      <= 1'b0;
			ex_mem_load    <= 1'b0;
			ex_reg_we      <= 1'b0;
		end else begin
			ex_rs          <= bubble ? '0 : rs;
			ex_rt          <= bubble ? '0 : rt;
			ex_dst         <= bubble ? '0 : dst;
			ex_alu_op      <= bubble ? mips_pkg::ALU_AND : alu_op;
			ex_alu_src_imm <= alu_src_imm & ~bubble;
			ex_branch      <= branch & ~bubble;
			ex_branch_ne   <= branch_ne & ~bubble;
			ex_jump        <= jump & ~bubble;
			ex_mem_we      <= mem_we & ~bubble;
			ex_mem_load    <= mem_load & ~bubble;
			ex_reg_we      <= reg_we & ~bubble;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc4         <= id_pc4;
		ex_rs_val      <= rs_val;
		ex_rt_val      <= rt_val;
		ex_imm         <= imm;
		ex_jtarget_idx <= id_instr[25:0];
	end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  mips_pkg::word_t     ex_pc4,
	input  mips_pkg::word_t     ex_rs_val,
	input  mips_pkg::word_t     ex_rt_val,
	input  mips_pkg::word_t     ex_imm,
	input  logic [25:0]         ex_jtarget_idx,
	input  mips_pkg::reg_addr_t ex_dst,
	input  mips_pkg::alu_op_e   ex_alu_op,
	input  logic                ex_alu_src_imm,
	input  logic                ex_branch,
	input  logic                ex_branch_ne,
	input  logic                ex_jump,
	input  logic                ex_mem_we,
	input  logic                ex_mem_load,
	input  logic                ex_reg_we,
	input  mips_pkg::fwd_sel_e  fwd_a,
	input  mips_pkg::fwd_sel_e  fwd_b,
	input  mips_pkg::word_t     wb_data,
	output logic                redirect,
	output mips_pkg::word_t     redirect_pc,
	output mips_pkg::word_t     mem_alu,
	output mips_pkg::word_t     mem_store_data,
	output logic                mem_we,
	output logic                mem_load,
	output mips_pkg::reg_addr_t mem_dst,
	output logic                mem_reg_we
);

	mips_pkg::word_t op_a;
	mips_pkg::word_t op_b_reg;
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_y;
	mips_pkg::word_t branch_target;
	mips_pkg::word_t jump_target;
	logic            taken;

	function automatic mips_pkg::word_t fwd_mux(
		input mips_pkg::fwd_sel_e sel,
		input mips_pkg::word_t    reg_val,
		input mips_pkg::word_t    mem_val,
		input mips_pkg::word_t    wb_val
	);
		case (sel)
			mips_pkg::FWD_MEM: return mem_val;
			mips_pkg::FWD_WB:  return wb_val;
			default:           return reg_val;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Operand select and ALU
	// ------------------------------------------------------------------------
	assign op_a     = fwd_mux(fwd_a, ex_rs_val, mem_alu, wb_data);
	assign op_b_reg = fwd_mux(fwd_b, ex_rt_val, mem_alu, wb_data);	// Also store data
	assign op_b     = ex_alu_src_imm ? ex_imm : op_b_reg;

	always_comb begin
		case (ex_alu_op)
			mips_pkg::ALU_OR:  alu_y = op_a | op_b;
			mips_pkg::ALU_ADD: alu_y = op_a + op_b;
			mips_pkg::ALU_SUB: alu_y = op_a - op_b;
			mips_pkg::ALU_SLT: alu_y = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			default:           alu_y = op_a & op_b;
		endcase
	end

	// ------------------------------------------------------------------------
	// Branch and jump resolution
	// ------------------------------------------------------------------------
	assign taken         = ex_branch & ((op_a == op_b_reg) ^ ex_branch_ne);
	assign branch_target = ex_pc4 + {ex_imm[29:0], 2'b00};
	assign jump_target   = {ex_pc4[31:28], ex_jtarget_idx, 2'b00};

	assign redirect    = taken | ex_jump;
	assign redirect_pc = ex_jump ? jump_target : branch_target;

	// EX/MEM register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_we     <= 1'b0;
			mem_load   <= 1'b0;
			mem_dst    <= '0;
			mem_reg_we <= 1'b0;
		end else begin
			mem_we     <= ex_mem_we;
			mem_load   <= ex_mem_load;
			mem_dst    <= ex_dst;
			mem_reg_we <= ex_reg_we;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu        <= alu_y;
		mem_store_data <= op_b_reg;
	end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter mips_pkg::word_t RESET_PC = '0
) (
	input  logic                clk,
	input  logic                arst_n,
	input  mips_pkg::word_t     instr,
	input  logic                stall,
	input  logic                redirect,
	input  mips_pkg::word_t     redirect_pc,
	output mips_pkg::word_t     pc,
	output mips_pkg::word_t     id_pc4,
	output mips_pkg::word_t     id_instr,
	output mips_pkg::reg_addr_t id_rs,
	output mips_pkg::reg_addr_t id_rt
);

	mips_pkg::word_t pc4;
	mips_pkg::word_t pc_next;

	assign pc4 = pc + 32'd4;

	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;	// Taken branch or jump wins
		end else if (stall) begin
			pc_next = pc;	// Load-use hold
		end else begin
			pc_next = pc4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// ------------------------------------------------------------------------
	// IF/ID register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_instr <= '0;
		end else if (redirect) begin
			id_instr <= '0;	// All-zero word decodes as a no-op
		end else if (!stall) begin
			id_instr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc4 <= pc4;
		end
	end

	assign id_rs = id_instr[25:21];
	assign id_rt = id_instr[20:16];

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  mips_pkg::reg_addr_t id_rs,
	input  mips_pkg::reg_addr_t id_rt,
	input  mips_pkg::reg_addr_t ex_rs,
	input  mips_pkg::reg_addr_t ex_rt,
	input  mips_pkg::reg_addr_t ex_dst,
	input  logic                ex_mem_load,
	input  mips_pkg::reg_addr_t mem_dst,
	input  logic                mem_reg_we,
	input  mips_pkg::reg_addr_t wb_dst,
	input  logic                wb_we,
	output mips_pkg::fwd_sel_e  fwd_a,
	output mips_pkg::fwd_sel_e  fwd_b,
	output logic                stall
);

	// Youngest producer wins, r0 never forwards
	function automatic mips_pkg::fwd_sel_e fwd_pick(
		input mips_pkg::reg_addr_t src,
		input mips_pkg::reg_addr_t m_dst,
		input logic                m_we,
		input mips_pkg::reg_addr_t w_dst,
		input logic                w_we
	);
		if (m_we && m_dst != '0 && m_dst == src) begin
			return mips_pkg::FWD_MEM;
		end else if (w_we && w_dst != '0 && w_dst == src) begin
			return mips_pkg::FWD_WB;
		end
		return mips_pkg::FWD_NONE;
	endfunction

	assign fwd_a = fwd_pick(ex_rs, mem_dst, mem_reg_we, wb_dst, wb_we);
	assign fwd_b = fwd_pick(ex_rt, mem_dst, mem_reg_we, wb_dst, wb_we);

	assign stall = ex_mem_load && ex_dst != '0 && (ex_dst == id_rs || ex_dst == id_rt);

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  mips_pkg::word_t     memreaddata,
	input  mips_pkg::word_t     mem_alu,
	input  logic                mem_load,
	input  mips_pkg::reg_addr_t mem_dst,
	input  logic                mem_reg_we,
	output logic                wb_we,
	output mips_pkg::reg_addr_t wb_dst,
	output mips_pkg::word_t     wb_data
);

	mips_pkg::word_t result;

	assign result = mem_load ? memreaddata : mem_alu;	// Load data or ALU result

	// MEM/WB register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_we  <= 1'b0;
			wb_dst <= '0;
		end else begin
			wb_we  <= mem_reg_we;
			wb_dst <= mem_dst;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= result;
	end

endmodule

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
	parameter mips_pkg::word_t RESET_PC = '0
) (
	input  logic            clk,
	input  logic            arst_n,
	output mips_pkg::word_t pc,
	input  mips_pkg::word_t instr,
	output logic            memwrite,
	output mips_pkg::word_t memaddr,
	output mips_pkg::word_t memwritedata,
	input  mips_pkg::word_t memreaddata
);

	// IF/ID
	mips_pkg::word_t     if_pc4;
	mips_pkg::word_t     if_instr;
	mips_pkg::reg_addr_t id_rs;
	mips_pkg::reg_addr_t id_rt;

	// ID/EX
	mips_pkg::word_t     ex_pc4;
	mips_pkg::word_t     ex_rs_val;
	mips_pkg::word_t     ex_rt_val;
	mips_pkg::word_t     ex_imm;
	logic [25:0]         ex_jtarget_idx;
	mips_pkg::reg_addr_t ex_rs;
	mips_pkg::reg_addr_t ex_rt;
	mips_pkg::reg_addr_t ex_dst;
	mips_pkg::alu_op_e   ex_alu_op;
	logic                ex_alu_src_imm;
	logic                ex_branch;
	logic                ex_branch_ne;
	logic                ex_jump;
	logic                ex_mem_we;
	logic                ex_mem_load;
	logic                ex_reg_we;

	// EX/MEM
	mips_pkg::word_t     mem_alu;
	mips_pkg::word_t     mem_store_data;
	logic                mem_we;
	logic                mem_load;
	mips_pkg::reg_addr_t mem_dst;
	logic                mem_reg_we;

	// MEM/WB
	logic                wb_we;
	mips_pkg::reg_addr_t wb_dst;
	mips_pkg::word_t     wb_data;

	// Hazard control
	mips_pkg::fwd_sel_e  fwd_a;
	mips_pkg::fwd_sel_e  fwd_b;
	logic                stall;
	logic                redirect;
	mips_pkg::word_t     redirect_pc;

	assign memaddr      = mem_alu;
	assign memwritedata = mem_store_data;
	assign memwrite     = mem_we;

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.id_pc4      (if_pc4),
		.id_instr    (if_instr),
		.id_rs       (id_rs),
		.id_rt       (id_rt)
	);

	decode_stage u_decode (
		.clk            (clk),
		.arst_n         (arst_n),
		.id_pc4         (if_pc4),
		.id_instr       (if_instr),
		.stall          (stall),
		.redirect       (redirect),
		.wb_we          (wb_we),
		.wb_dst         (wb_dst),
		.wb_data        (wb_data),
		.ex_pc4         (ex_pc4),
		.ex_rs_val      (ex_rs_val),
		.ex_rt_val      (ex_rt_val),
		.ex_imm         (ex_imm),
		.ex_jtarget_idx (ex_jtarget_idx),
		.ex_rs          (ex_rs),
		.ex_rt          (ex_rt),
		.ex_dst         (ex_dst),
		.ex_alu_op      (ex_alu_op),
		.ex_alu_src_imm (ex_alu_src_imm),
		.ex_branch      (ex_branch),
		.ex_branch_ne   (ex_branch_ne),
		.ex_jump        (ex_jump),
		.ex_mem_we      (ex_mem_we),
		.ex_mem_load    (ex_mem_load),
		.ex_reg_we      (ex_reg_we)
	);

	execute_stage u_execute (
		.clk            (clk),
		.arst_n         (arst_n),
		.ex_pc4         (ex_pc4),
		.ex_rs_val      (ex_rs_val),
		.ex_rt_val      (ex_rt_val),
		.ex_imm         (ex_imm),
		.ex_jtarget_idx (ex_jtarget_idx),
		.ex_dst         (ex_dst),
		.ex_alu_op      (ex_alu_op),
		.ex_alu_src_imm (ex_alu_src_imm),
		.ex_branch      (ex_branch),
		.ex_branch_ne   (ex_branch_ne),
		.ex_jump        (ex_jump),
		.ex_mem_we      (ex_mem_we),
		.ex_mem_load    (ex_mem_load),
		.ex_reg_we      (ex_reg_we),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.wb_data        (wb_data),
		.redirect       (redirect),
		.redirect_pc    (redirect_pc),
		.mem_alu        (mem_alu),
		.mem_store_data (mem_store_data),
		.mem_we         (mem_we),
		.mem_load       (mem_load),
		.mem_dst        (mem_dst),
		.mem_reg_we     (mem_reg_we)
	);

	mem_stage u_mem (
		.clk         (clk),
		.arst_n      (arst_n),
		.memreaddata (memreaddata),
		.mem_alu     (mem_alu),
		.mem_load    (mem_load),
		.mem_dst     (mem_dst),
		.mem_reg_we  (mem_reg_we),
		.wb_we       (wb_we),
		.wb_dst      (wb_dst),
		.wb_data     (wb_data)
	);

	hazard_unit u_hazard (
		.id_rs       (id_rs),
		.id_rt       (id_rt),
		.ex_rs       (ex_rs),
		.ex_rt       (ex_rt),
		.ex_dst      (ex_dst),
		.ex_mem_load (ex_mem_load),
		.mem_dst     (mem_dst),
		.mem_reg_we  (mem_reg_we),
		.wb_dst      (wb_dst),
		.wb_we       (wb_we),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.stall       (stall)
	);

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

	// ------------------------------------------------------------------------
	// Widths and word types
	// ------------------------------------------------------------------------
	parameter int XLEN   = 32;	// Data and address width
	parameter int REG_AW = 5;	// Register number width

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;	// r0 reads zero, ignores writes

	// ------------------------------------------------------------------------
	// Instruction encodings
	// ------------------------------------------------------------------------
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,	// Same datapath as ADDI, no overflow trap
		OP_ORI   = 6'b001101,
		OP_LUI   = 6'b001111,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		F_ADD  = 6'b100000,
		F_ADDU = 6'b100001,
		F_SUB  = 6'b100010,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_SLT  = 6'b101010
	} funct_e;

	// ------------------------------------------------------------------------
	// Datapath selects
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		ALU_AND = 3'b000,
		ALU_OR  = 3'b001,
		ALU_ADD = 3'b010,
		ALU_SUB = 3'b110,
		ALU_SLT = 3'b111	// Signed compare, result 1 or 0
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,	// Value read in decode
		FWD_MEM  = 2'b01,	// ALU result in memory stage
		FWD_WB   = 2'b10	// Result being written back
	} fwd_sel_e;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the MIPS core testbench with Verilator.
# The exit status is the simulator's: a $fatal anywhere gives a failing status.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	-f src.f --top-module mips_core_tb -o mips_core_sim &&
./obj_dir/mips_core_sim || {
	echo "Simulation failed" >&2
	exit 1
}

// ==== src.f ====
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/hazard_unit.sv
hw/mips_core.sv
verif/mips_core_props.sv
verif/mips_core_tb.sv

// ==== verif/mips_core_props.sv ====
`timescale 1ns/1ps

module mips_core_props #(
	parameter mips_pkg::word_t RESET_PC = '0
) (
	input logic            clk,
	input logic            arst_n,
	input mips_pkg::word_t pc,
	input logic            memwrite,
	input mips_pkg::word_t memaddr
);

	// No store may leave the core while reset is held
	a_no_write_in_reset: assert property (@(posedge clk) !arst_n |-> !memwrite)
		else $error("memwrite high during reset");

	a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

	// Second reset cycle onward, pc already loaded
	a_pc_reset: assert property (@(posedge clk) (!arst_n ##1 !arst_n) |-> pc == RESET_PC)
		else $error("pc differs from reset address during reset");

	a_store_aligned: assert property (@(posedge clk) memwrite |-> memaddr[1:0] == 2'b00)
		else $error("store address not word aligned");

endmodule

bind mips_core mips_core_props #(
	.RESET_PC (RESET_PC)
) u_props (
	.clk      (clk),
	.arst_n   (arst_n),
	.pc       (pc),
	.memwrite (memwrite),
	.memaddr  (memaddr)
);

// ==== verif/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

	localparam mips_pkg::word_t RESET_PC    = 32'h0000_0040;
	localparam int              TEST_CYCLES = 400;	// Upper bound for all five tests
	localparam time             WATCHDOG_NS = (TEST_CYCLES * 2 + 100) * 100;

	logic            clk;
	logic            arst_n;
	mips_pkg::word_t pc;
	mips_pkg::word_t instr;
	logic            memwrite;
	mips_pkg::word_t memaddr;
	mips_pkg::word_t memwritedata;
	mips_pkg::word_t memreaddata;

	mips_pkg::word_t imem [256];
	mips_pkg::word_t dmem [256];
	mips_pkg::word_t st_addr [$];	// Captured stores
	mips_pkg::word_t st_data [$];
	mips_pkg::word_t exp_addr [$];	// Expected stores in program order
	mips_pkg::word_t exp_data [$];
	mips_pkg::word_t emit_pc;
	int              seed = 32'h9ccd;
	int              n_checks = 0;

	mips_core #(
		.RESET_PC (RESET_PC)
	) u_mips_core (
		.clk          (clk),
		.arst_n       (arst_n),
		.pc           (pc),
		.instr        (instr),
		.memwrite     (memwrite),
		.memaddr      (memaddr),
		.memwritedata (memwritedata),
		.memreaddata  (memreaddata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Memory models
	// ------------------------------------------------------------------------
	assign instr       = imem[pc[9:2]];
	assign memreaddata = dmem[memaddr[9:2]];

	always @(posedge clk) begin
		if (arst_n && memwrite) begin
			dmem[memaddr[9:2]] <= memwritedata;
			st_addr.push_back(memaddr);
			st_data.push_back(memwritedata);
		end
	end

	// ------------------------------------------------------------------------
	// Instruction encoders and program builder
	// ------------------------------------------------------------------------
	function automatic mips_pkg::word_t enc_r(mips_pkg::funct_e f, mips_pkg::reg_addr_t rd,
			mips_pkg::reg_addr_t rs, mips_pkg::reg_addr_t rt);
		return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, f};
	endfunction

	function automatic mips_pkg::word_t enc_i(mips_pkg::opcode_e op, mips_pkg::reg_addr_t rt,
			mips_pkg::reg_addr_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::word_t enc_j(mips_pkg::word_t target);
		return {mips_pkg::OP_J, target[27:2]};
	endfunction

	function automatic mips_pkg::word_t sext16(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic emit(mips_pkg::word_t w);
		imem[emit_pc[9:2]] = w;
		emit_pc += 32'd4;
	endtask

	task automatic load_reg(mips_pkg::reg_addr_t r, mips_pkg::word_t v);
		emit(enc_i(mips_pkg::OP_LUI, r, 5'd0, v[31:16]));
		emit(enc_i(mips_pkg::OP_ORI, r, r, v[15:0]));
	endtask

	task automatic store(mips_pkg::reg_addr_t r, logic [15:0] addr, mips_pkg::word_t v);
		emit(enc_i(mips_pkg::OP_SW, r, 5'd0, addr));
		exp_addr.push_back({16'h0000, addr});
		exp_data.push_back(v);
	endtask

	task automatic halt();
		emit(enc_j(emit_pc));	// Jump to itself
	endtask

	// Holds reset for three cycles while a fresh program is written
	task automatic start_program();
		@(posedge clk);
		arst_n <= 1'b0;
		foreach (imem[i]) imem[i] = '0;
		emit_pc = RESET_PC;
		st_addr.delete();
		st_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic fail_now(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Testbench stopped at first error");
	endtask

	task automatic check_word(string name, mips_pkg::word_t got, mips_pkg::word_t exp);
		n_checks++;
		if (got !== exp)
			fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(string name, mips_pkg::word_t got, mips_pkg::word_t exp);
		n_checks++;
		if (got !== exp)
			fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_pc(string name, mips_pkg::word_t got, mips_pkg::word_t exp);
		n_checks++;
		if (got !== exp)
			fail_now($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	// Runs until all expected stores are seen, then checks for strays
	task automatic run_and_check(string test);
		release_reset();
		while (st_addr.size() < exp_addr.size()) @(posedge clk);
		repeat (12) @(posedge clk);
		if (st_addr.size() != exp_addr.size())
			fail_now($sformatf("%s: saw %0d stores but expected %0d", test,
				st_addr.size(), exp_addr.size()));
		foreach (exp_addr[i]) begin
			check_addr($sformatf("%s memaddr[%0d]", test, i), st_addr[i], exp_addr[i]);
			check_word($sformatf("%s memwritedata[%0d]", test, i), st_data[i], exp_data[i]);
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_fetch();
		start_program();
		for (int i = 0; i < 12; i++) begin
			emit(enc_i(mips_pkg::OP_ADDI, 5'(i % 8 + 1), 5'd0, 16'(i)));
		end
		release_reset();
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_pc("pc", pc, RESET_PC + 32'(4 * i));
		end
		if (st_addr.size() != 0)
			fail_now("reset_fetch: a store appeared in a program without stores");
	endtask

	task automatic test_alu_ops();
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		logic [15:0]     imm;
		a   = $random(seed);
		b   = $random(seed);
		imm = 16'($random(seed));
		start_program();
		load_reg(5'd1, a);
		load_reg(5'd2, b);
		emit(enc_r(mips_pkg::F_ADD, 5'd3, 5'd1, 5'd2));
		store(5'd3, 16'h0200, a + b);
		emit(enc_r(mips_pkg::F_SUB, 5'd3, 5'd1, 5'd2));
		store(5'd3, 16'h0204, a - b);
		emit(enc_r(mips_pkg::F_AND, 5'd3, 5'd1, 5'd2));
		store(5'd3, 16'h0208, a & b);
		emit(enc_r(mips_pkg::F_OR, 5'd3, 5'd1, 5'd2));
		store(5'd3, 16'h020c, a | b);
		emit(enc_r(mips_pkg::F_SLT, 5'd3, 5'd1, 5'd2));
		store(5'd3, 16'h0210, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		emit(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd1, imm));
		store(5'd3, 16'h0214, a + sext16(imm));
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd3, 5'd2, imm));
		store(5'd3, 16'h0218, b + sext16(imm));
		halt();
		run_and_check("alu_ops");
	endtask

	task automatic test_forwarding();
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t c;
		mips_pkg::word_t d;
		mips_pkg::word_t e;
		mips_pkg::word_t f;
		mips_pkg::word_t g;
		a = $random(seed);
		b = $random(seed);
		c = a + b;
		d = c - b;
		e = c | d;
		f = e & a;
		g = ($signed(f) < $signed(d)) ? 32'd1 : 32'd0;
		start_program();
		load_reg(5'd1, a);
		load_reg(5'd2, b);
		emit(enc_r(mips_pkg::F_ADDU, 5'd3, 5'd1, 5'd2));
		emit(enc_r(mips_pkg::F_SUBU, 5'd4, 5'd3, 5'd2));	// Distance one
		emit(enc_r(mips_pkg::F_OR, 5'd5, 5'd3, 5'd4));	// Distances two and one
		store(5'd5, 16'h0240, e);
		emit(enc_r(mips_pkg::F_AND, 5'd6, 5'd5, 5'd1));
		emit(enc_r(mips_pkg::F_SLT, 5'd7, 5'd6, 5'd4));
		store(5'd6, 16'h0244, f);
		store(5'd7, 16'h0248, g);
		emit(enc_i(mips_pkg::OP_ADDI, 5'd8, 5'd7, 16'h7ff0));
		store(5'd8, 16'h024c, g + 32'h0000_7ff0);
		store(5'd4, 16'h0250, d);
		halt();
		run_and_check("forwarding");
	endtask

	task automatic test_load_use();
		mips_pkg::word_t a;
		a = $random(seed);
		start_program();
		load_reg(5'd1, a);
		store(5'd1, 16'h0100, a);
		emit(enc_i(mips_pkg::OP_LW, 5'd2, 5'd0, 16'h0100));
		emit(enc_r(mips_pkg::F_ADD, 5'd3, 5'd2, 5'd1));	// Needs the load at once
		store(5'd3, 16'h0104, a + a);
		halt();
		run_and_check("load_use");
	endtask

	task automatic test_control_flow();
		start_program();
		emit(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
		emit(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd5));
		emit(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'd7));
		emit(enc_i(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'h0011));
		emit(enc_i(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));	// Taken
		emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0300));
		emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0304));
		emit(enc_i(mips_pkg::OP_BEQ, 5'd3, 5'd1, 16'd2));	// Not taken
		store(5'd4, 16'h0308, 32'h0000_0011);
		store(5'd4, 16'h030c, 32'h0000_0011);
		emit(enc_i(mips_pkg::OP_BNE, 5'd3, 5'd1, 16'd2));	// Taken
		emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0310));
		emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0314));
		emit(enc_i(mips_pkg::OP_BNE, 5'd2, 5'd1, 16'd2));	// Not taken
		store(5'd4, 16'h0318, 32'h0000_0011);
		store(5'd4, 16'h031c, 32'h0000_0011);
		emit(enc_j(emit_pc + 32'd12));
		emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0320));
		emit(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'h0324));
		store(5'd4, 16'h0328, 32'h0000_0011);
		halt();
		run_and_check("control_flow");
	endtask

	// ------------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		arst_n = 1'b0;
		foreach (dmem[i]) dmem[i] <= 32'hd0a0_0000 ^ (i << 2);	// Byte address pattern
		foreach (imem[i]) imem[i] = '0;
		test_reset_fetch();
		test_alu_ops();
		test_forwarding();
		test_load_use();
		test_control_flow();
		if (n_checks > 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("No check ran");
			$display("CHECKS FAILED");
			$fatal(1, "Empty run");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$fatal(1, "Timeout");
	end

endmodule
